// ==== flist.f ====
+incdir+logic
logic/host_bus_pkg.sv
logic/nes_io_pkg.sv
logic/uart_reg_decode.sv
logic/joypad_port.sv
logic/mem_slot_sched.sv
logic/nes_host_top.sv
verif/nes_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the NES host testbench with Verilator
# exit status is nonzero when the testbench stops on an error
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
  -f flist.f \
  --top-module nes_host_tb \
  -o nes_host_sim
./obj_dir/nes_host_sim

// ==== verif/nes_host_tb.sv ====
// NES host glue testbench
// per-cycle stimulus table, expected values from reference models of the
// decoder, the pad ports and the slot scheduler

`timescale 1ns/1ps
`default_nettype none

`include "nes_host_params.svh"

module nes_host_tb;

  import host_bus_pkg::*;
  import nes_io_pkg::*;

  typedef struct packed {
    uart_wr_t       uart;
    pad_raw_t       pad1;
    pad_raw_t       pad2;
    logic           strobe;
    logic [1:0]     jclk;
    nes_mem_req_t   req;
    loader_wr_t     ldr;
    logic           done;
    loader_byte_t   byte_exp;
    logic           lreset_exp;
    logic [1:0]     jdata_exp;
    mem_cmd_t       cmd_exp;
    logic           run_exp;
    nes_btn_t [1:0] word_exp; // latch right after a strobe
  } entry_t;

  logic         clk;
  logic         sys_resetn;
  uart_wr_t     uart_wr;
  pad_raw_t     pad1_raw;
  pad_raw_t     pad2_raw;
  logic         joypad_strobe;
  logic [1:0]   joypad_clock;
  nes_mem_req_t nes_req;
  loader_wr_t   loader_wr;
  logic         loader_done;
  loader_byte_t loader_byte;
  logic         loader_reset;
  logic [1:0]   joypad_data;
  mem_cmd_t     mem_cmd;
  logic         run_nes;

  entry_t   tbl[$];
  entry_t   stim; // current input levels while the table is built
  nes_btn_t rx [2];
  nes_btn_t rx_word [2];
  int       rx_cnt [2];
  int       wd_limit = 0;

  nes_host_top dut_i (
    .clk(clk), .sys_resetn(sys_resetn), .uart_wr(uart_wr),
    .pad1_raw(pad1_raw), .pad2_raw(pad2_raw),
    .joypad_strobe(joypad_strobe), .joypad_clock(joypad_clock),
    .nes_req(nes_req), .loader_wr(loader_wr), .loader_done(loader_done),
    .loader_byte(loader_byte), .loader_reset(loader_reset),
    .joypad_data(joypad_data), .mem_cmd(mem_cmd), .run_nes(run_nes)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_cmd(mem_cmd_t exp, mem_cmd_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: mem_cmd expected %h, got %h", $time, exp, act);
      stop_run();
    end
  endtask

  task automatic check_byte(loader_byte_t exp, loader_byte_t act);
    // data only counts while the strobe is up
    if (act.strobe !== exp.strobe || (exp.strobe && act.data !== exp.data)) begin
      $display("Mismatch at %0t ns: loader_byte expected %h, got %h", $time, exp, act);
      stop_run();
    end
  endtask

  task automatic check_word(string name, nes_btn_t exp, nes_btn_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // autofire level after held_n edges with the button down
  function automatic logic af_level(int held_n);
    return held_n > 0 && ((held_n - 1) / `NH_AUTOFIRE_HALF) % 2 == 0;
  endfunction

  function automatic nes_btn_t map_pad(pad_raw_t p, logic af_sq, logic af_tri);
    nes_btn_t b;
    b.r      = !p.byte0[5];
    b.l      = !p.byte0[7];
    b.d      = !p.byte0[6];
    b.u      = !p.byte0[4];
    b.start  = !p.byte0[3];
    b.select = !p.byte0[0];
    b.b      = !p.byte1[6] || af_sq;
    b.a      = !p.byte1[5] || af_tri;
    return b;
  endfunction

  function automatic pad_raw_t random_pad();
    pad_raw_t p;
    p = 16'($urandom);
    p.byte1[7] = 1'b1; // autofire buttons released
    p.byte1[4] = 1'b1;
    return p;
  endfunction

  function automatic nes_mem_req_t random_req();
    nes_mem_req_t r;
    r.addr     = 22'($urandom);
    r.dout     = 8'($urandom);
    r.read_cpu = ($urandom_range(3) == 0);
    r.read_ppu = ($urandom_range(3) == 0);
    r.write    = ($urandom_range(3) == 0);
    return r;
  endfunction

  function automatic loader_wr_t random_loader();
    loader_wr_t w;
    w.addr    = 22'($urandom);
    w.data    = 8'($urandom);
    w.write   = ($urandom_range(3) == 0);
    w.refresh = ($urandom_range(2) == 0);
    return w;
  endfunction

  task automatic hold(int n);
    repeat (n) begin
      tbl.push_back(stim);
      stim.uart.write = 1'b0; // single cycle write
    end
  endtask

  task automatic uart_write(uart_reg_e addr, logic [7:0] data);
    stim.uart.addr  = addr;
    stim.uart.data  = data;
    stim.uart.write = 1'b1;
    hold(1);
  endtask

  // console strobe, then clock pulses on one port
  task automatic read_pad(int port, int pulses);
    stim.strobe = 1'b1;
    hold(1);
    stim.strobe = 1'b0;
    repeat (pulses) begin
      stim.jclk[port] = 1'b1;
      hold(1);
      stim.jclk[port] = 1'b0;
      hold(1);
    end
  endtask

  task automatic build_table();
    stim = '0;
    stim.pad1 = '1;
    stim.pad2 = '1;
    hold(2);
    uart_write(reg_rom, 8'ha5);
    hold(3);
    uart_write(reg_rom, 8'h3c);
    uart_write(reg_rom, 8'hc3); // back to back bytes
    hold(2);
    uart_write(reg_conf, 8'h01);
    hold(2);
    uart_write(uart_reg_e'(8'h36), 8'hfe); // unmapped address
    hold(2);
    uart_write(reg_conf, 8'h00);
    hold(2);
    repeat (3) begin
      uart_write(reg_btn1, 8'($urandom));
      uart_write(reg_btn2, 8'($urandom));
      stim.pad1 = random_pad();
      stim.pad2 = random_pad();
      hold(1);
      read_pad(0, 10);
      read_pad(1, 10);
    end
    uart_write(reg_btn1, 8'h00);
    stim.pad1 = '1;
    hold(1);
    stim.pad1.byte1[7] = 1'b0; // square held
    for (int k = 0; k < 8; k++) begin
      hold(k % 3); // uneven strobe offsets
      read_pad(0, 1);
    end
    stim.pad1.byte1[7] = 1'b1;
    hold(1);
    read_pad(0, 1);
    repeat (8) begin
      stim.req = random_req();
      stim.ldr = random_loader();
      hold(1);
    end
    stim.done = 1'b1;
    stim.req  = '0;
    stim.ldr  = '0;
    hold(1); // idle run_mem slot asks for refresh
    stim.ldr.refresh = 1'b1;
    hold(1); // loader refresh outside run_mem
    repeat (40) begin
      stim.req = random_req();
      stim.ldr = random_loader();
      hold(1);
    end
    stim.done = 1'b0;
    stim.ldr  = '0;
    hold(3);
  endtask

  task automatic build_expected();
    logic         conf0 = 1'b0;
    nes_btn_t     btn [2];
    nes_btn_t     latch [2];
    loader_byte_t lb = '0;
    logic [1:0]   prev_clk = '0;
    int           held [2][2]; // port, square/triangle
    int           ph = 0;
    logic         run_mem;
    logic         idle;
    pad_raw_t     pad;
    entry_t       e;
    for (int p = 0; p < 2; p++) begin
      btn[p] = '0;
      latch[p] = '0;
      held[p][0] = 0;
      held[p][1] = 0;
    end
    foreach (tbl[i]) begin
      e = tbl[i];
      e.byte_exp   = lb;
      e.lreset_exp = conf0;
      e.jdata_exp  = {latch[1][0], latch[0][0]};
      run_mem      = e.done && ph == 0;
      e.run_exp    = e.done && ph == `NH_NES_PHASE;
      idle         = !e.req.read_cpu && !e.req.read_ppu && !e.req.write;
      e.cmd_exp.read_a  = e.req.read_cpu && run_mem;
      e.cmd_exp.read_b  = e.req.read_ppu && run_mem;
      e.cmd_exp.write   = (e.req.write && run_mem) || e.ldr.write;
      e.cmd_exp.refresh = (run_mem && idle && !e.ldr.write) || (e.ldr.refresh && !e.ldr.write);
      e.cmd_exp.addr    = e.ldr.write ? e.ldr.addr : e.req.addr;
      e.cmd_exp.din     = e.ldr.write ? e.ldr.data : e.req.dout;
      // pads see the button registers from before this edge
      for (int p = 0; p < 2; p++) begin
        pad = (p == 0) ? e.pad1 : e.pad2;
        if (e.strobe) begin
          latch[p] = btn[p] | map_pad(pad, af_level(held[p][0]), af_level(held[p][1]));
        end else if (prev_clk[p] && !e.jclk[p]) begin
          latch[p] = {1'b0, latch[p][7:1]};
        end
        e.word_exp[p] = latch[p];
        prev_clk[p]   = e.jclk[p];
        held[p][0]    = pad.byte1[7] ? 0 : held[p][0] + 1;
        held[p][1]    = pad.byte1[4] ? 0 : held[p][1] + 1;
      end
      lb.strobe = e.uart.write && 8'(e.uart.addr) == `NH_REG_ROM;
      if (lb.strobe) lb.data = e.uart.data;
      if (e.uart.write && 8'(e.uart.addr) == `NH_REG_CONF) conf0 = e.uart.data[0];
      if (e.uart.write && 8'(e.uart.addr) == `NH_REG_BTN1) btn[0] = e.uart.data;
      if (e.uart.write && 8'(e.uart.addr) == `NH_REG_BTN2) btn[1] = e.uart.data;
      ph = e.done ? (ph + 1) % `NH_PHASES : 0;
      tbl[i] = e;
    end
  endtask

  task automatic drive(entry_t e);
    uart_wr       = e.uart;
    pad1_raw      = e.pad1;
    pad2_raw      = e.pad2;
    joypad_strobe = e.strobe;
    joypad_clock  = e.jclk;
    nes_req       = e.req;
    loader_wr     = e.ldr;
    loader_done   = e.done;
  endtask

  // rebuild the serial word from the bits seen before each shift
  task automatic collect_serial(int i);
    for (int p = 0; p < 2; p++) begin
      if (tbl[i].strobe) begin
        rx_word[p] = tbl[i].word_exp[p];
        rx_cnt[p]  = 0;
      end else if (i > 0 && tbl[i-1].jclk[p] && !tbl[i].jclk[p]) begin
        rx[p] = {joypad_data[p], rx[p][7:1]};
        rx_cnt[p]++;
        if (rx_cnt[p] == 8) check_word($sformatf("pad%0d word", p + 1), rx_word[p], rx[p]);
      end
    end
  endtask

  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge clk);
    $display("Something failed");
    $fatal(1, "simulation timed out");
  end

  initial begin
    sys_resetn = 1'b0;
    stim = '0;
    stim.pad1 = '1;
    stim.pad2 = '1;
    drive(stim);
    rx_cnt[0] = 0;
    rx_cnt[1] = 0;
    void'($urandom(32'h922051b8));
    build_table();
    build_expected();
    wd_limit = tbl.size() * 40 + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit("loader_reset", 1'b1, loader_reset); // high while in reset
    check_bit("run_nes", 1'b0, run_nes);
    @(posedge clk);
    foreach (tbl[i]) begin
      @(negedge clk);
      sys_resetn = 1'b1;
      drive(tbl[i]);
      #2;
      check_byte(tbl[i].byte_exp, loader_byte);
      check_bit("loader_reset", tbl[i].lreset_exp, loader_reset);
      check_bit("joypad_data[0]", tbl[i].jdata_exp[0], joypad_data[0]);
      check_bit("joypad_data[1]", tbl[i].jdata_exp[1], joypad_data[1]);
      check_bit("run_nes", tbl[i].run_exp, run_nes);
      check_cmd(tbl[i].cmd_exp, mem_cmd);
      collect_serial(i);
    end
    @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/nes_host_top.sv ====
// NES host glue top level
// UART register decode, two controller ports and the memory slot scheduler

`timescale 1ns/1ps
`default_nettype none

module nes_host_top (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  host_bus_pkg::uart_wr_t      uart_wr,
  input  nes_io_pkg::pad_raw_t        pad1_raw,
  input  nes_io_pkg::pad_raw_t        pad2_raw,
  input  logic                        joypad_strobe,
  input  logic [1:0]                  joypad_clock,
  input  nes_io_pkg::nes_mem_req_t    nes_req,
  input  nes_io_pkg::loader_wr_t      loader_wr,
  input  logic                        loader_done,
  output host_bus_pkg::loader_byte_t  loader_byte,
  output logic                        loader_reset,
  output logic [1:0]                  joypad_data,
  output nes_io_pkg::mem_cmd_t        mem_cmd,
  output logic                        run_nes
);

  import nes_io_pkg::*;

  nes_btn_t btn1; // loader buttons from the host
  nes_btn_t btn2;

  uart_reg_decode decode_i (
    .clk          (clk),
    .sys_resetn   (sys_resetn),
    .uart_wr      (uart_wr),
    .btn1         (btn1),
    .btn2         (btn2),
    .loader_byte  (loader_byte),
    .loader_reset (loader_reset)
  );

  joypad_port pad1_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .pad_raw       (pad1_raw),
    .loader_btn    (btn1),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[0]),
    .joypad_data   (joypad_data[0])
  );

  joypad_port pad2_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .pad_raw       (pad2_raw),
    .loader_btn    (btn2),
    .joypad_strobe (joypad_strobe), // both ports latch together
    .joypad_clock  (joypad_clock[1]),
    .joypad_data   (joypad_data[1])
  );

  mem_slot_sched sched_i (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .loader_done (loader_done),
    .nes_req     (nes_req),
    .loader_wr   (loader_wr),
    .mem_cmd     (mem_cmd),
    .run_nes     (run_nes)
  );

endmodule

`default_nettype wire

// ==== logic/mem_slot_sched.sv ====
// memory slot scheduler
// five-phase enable that splits each console step into memory and run
// slots, and the arbiter between loader writes and console requests

`timescale 1ns/1ps
`default_nettype none

`include "nes_host_params.svh"

module mem_slot_sched (
  input  logic                     clk,
  input  logic                     sys_resetn,
  input  logic                     loader_done,
  input  nes_io_pkg::nes_mem_req_t nes_req,
  input  nes_io_pkg::loader_wr_t   loader_wr,
  output nes_io_pkg::mem_cmd_t     mem_cmd,
  output logic                     run_nes
);

  import nes_io_pkg::*;

  //  phase   | mem | act | rw | wait | nes | mem |
  //  memory  | cmd | ACT | RW |      |dout |     |
  //  console                         | run |
  localparam slot_e LAST_SLOT = slot_e'(`NH_PHASES - 1);

  slot_e phase;
  logic  run_mem;
  logic  req_idle;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= slot_mem;
    end else if (!loader_done) begin
      phase <= slot_mem; // parked until the ROM is in
    end else if (phase == LAST_SLOT) begin
      phase <= slot_mem;
    end else begin
      phase <= slot_e'(phase + 3'd1);
    end
  end

  assign run_mem = loader_done && (phase == slot_mem);
  assign run_nes = loader_done && (phase == slot_nes);

  assign req_idle = !nes_req.read_cpu && !nes_req.read_ppu && !nes_req.write;

  // command bus, loader writes win on any cycle
  always_comb begin
    mem_cmd.read_a  = nes_req.read_cpu && run_mem;
    mem_cmd.read_b  = nes_req.read_ppu && run_mem;
    mem_cmd.write   = (nes_req.write && run_mem) || loader_wr.write;
    // keep the rows alive on idle slots and when the loader asks
    mem_cmd.refresh = (req_idle && !loader_wr.write && run_mem) ||
                      (loader_wr.refresh && !loader_wr.write);
    if (loader_wr.write) begin
      mem_cmd.addr = loader_wr.addr;
      mem_cmd.din  = loader_wr.data;
    end else begin
      mem_cmd.addr = nes_req.addr;
      mem_cmd.din  = nes_req.dout;
    end
  end

endmodule

`default_nettype wire

// ==== logic/joypad_port.sv ====
// controller port
// maps Dualshock bytes to console buttons, adds autofire on B and A,
// and serves the console through a latch-and-shift register

`timescale 1ns/1ps
`default_nettype none

`include "nes_host_params.svh"

module joypad_port (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  nes_io_pkg::pad_raw_t pad_raw,
  input  nes_io_pkg::nes_btn_t loader_btn,
  input  logic                 joypad_strobe,
  input  logic                 joypad_clock,
  output logic                 joypad_data
);

  import nes_io_pkg::*;

  localparam int AF_W = $clog2(`NH_AUTOFIRE_HALF + 1);
  localparam logic [AF_W-1:0] AF_RELOAD = AF_W'(`NH_AUTOFIRE_HALF - 1);

  logic [1:0]      af_btn; // [0] square, [1] triangle
  logic [1:0]      af_q;
  logic [AF_W-1:0] af_cnt [2];
  nes_btn_t        mapped;
  logic [7:0]      shift_q;
  logic            clock_q;
  logic            clock_fall;

  // autofire buttons, made active high
  assign af_btn[0] = ~pad_raw.byte1[7];
  assign af_btn[1] = ~pad_raw.byte1[4];

  // square wave per held button, both channels share this code
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      af_q <= '0;
      for (int i = 0; i < 2; i++) begin
        af_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!af_btn[i]) begin
          af_q[i]   <= 1'b0; // drops on release
          af_cnt[i] <= '0;
        end else if (af_cnt[i] == '0) begin
          af_q[i]   <= ~af_q[i];
          af_cnt[i] <= AF_RELOAD;
        end else begin
          af_cnt[i] <= af_cnt[i] - 1'b1;
        end
      end
    end
  end

  // Dualshock to console order
  always_comb begin
    mapped.r      = ~pad_raw.byte0[5];
    mapped.l      = ~pad_raw.byte0[7];
    mapped.d      = ~pad_raw.byte0[6];
    mapped.u      = ~pad_raw.byte0[4];
    mapped.start  = ~pad_raw.byte0[3];
    mapped.select = ~pad_raw.byte0[0];
    mapped.b      = ~pad_raw.byte1[6] | af_q[0]; // X or square autofire
    mapped.a      = ~pad_raw.byte1[5] | af_q[1]; // O or triangle autofire
  end

  assign clock_fall = clock_q && !joypad_clock;

  // console side shift register
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q <= '0;
      clock_q <= 1'b0;
    end else begin
      clock_q <= joypad_clock;
      if (joypad_strobe) begin
        shift_q <= loader_btn | mapped; // reloads for as long as strobe is high
      end else if (clock_fall) begin
        shift_q <= {1'b0, shift_q[7:1]}; // zeros follow the last button
      end
    end
  end

  assign joypad_data = shift_q[0];

endmodule

`default_nettype wire

// ==== logic/uart_reg_decode.sv ====
// UART register decoder
// loader config, loader button registers and the ROM byte strobe

`timescale 1ns/1ps
`default_nettype none

module uart_reg_decode (
  input  logic                      clk,
  input  logic                      sys_resetn,
  input  host_bus_pkg::uart_wr_t    uart_wr,
  output nes_io_pkg::nes_btn_t      btn1,
  output nes_io_pkg::nes_btn_t      btn2,
  output host_bus_pkg::loader_byte_t loader_byte,
  output logic                      loader_reset
);

  import host_bus_pkg::*;

  logic conf_reset; // bit 0 of the conf register
  logic wr_conf;
  logic wr_rom;
  logic wr_btn1;
  logic wr_btn2;

  assign wr_conf = uart_wr.write && (uart_wr.addr == reg_conf);
  assign wr_rom  = uart_wr.write && (uart_wr.addr == reg_rom);
  assign wr_btn1 = uart_wr.write && (uart_wr.addr == reg_btn1);
  assign wr_btn2 = uart_wr.write && (uart_wr.addr == reg_btn2);

  always_ff @(posedge clk) begin
    if (wr_rom) begin
      loader_byte.data <= uart_wr.data; // held until the next ROM byte
    end

    if (!sys_resetn) begin
      conf_reset         <= 1'b0;
      btn1               <= '0;
      btn2               <= '0;
      loader_byte.strobe <= 1'b0;
    end else begin
      loader_byte.strobe <= wr_rom;
      if (wr_conf) begin
        conf_reset <= uart_wr.data[0];
      end
      if (wr_btn1) begin
        btn1 <= uart_wr.data;
      end
      if (wr_btn2) begin
        btn2 <= uart_wr.data;
      end
    end
  end

  // loader stays in reset with the system, or while the host holds it
  assign loader_reset = !sys_resetn || conf_reset;

endmodule

`default_nettype wire

// ==== logic/nes_io_pkg.sv ====
// console side types
// pad bytes, button vector, slot phases and the memory request/command buses

`default_nettype none

`include "nes_host_params.svh"

package nes_io_pkg;

  // raw Dualshock bytes, active low
  // byte0: L D R U St R3 L3 Se, byte1: square X O triangle R1 L1 R2 L2
  typedef struct packed {
    logic [7:0] byte0;
    logic [7:0] byte1;
  } pad_raw_t;

  // console button order, active high, a in bit 0
  typedef struct packed {
    logic r;
    logic l;
    logic d;
    logic u;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_btn_t;

  // phases of the enable cycle
  typedef enum logic [2:0] {
    slot_mem  = 3'd0, // command issued to memory
    slot_act  = 3'd1,
    slot_rw   = 3'd2,
    slot_wait = 3'd3,
    slot_nes  = 3'(`NH_NES_PHASE) // console step, read data is back
  } slot_e;

  // console memory request
  typedef struct packed {
    logic [`NH_ADDR_W-1:0] addr;
    logic                  read_cpu;
    logic                  read_ppu;
    logic                  write;
    logic [`NH_DATA_W-1:0] dout;
  } nes_mem_req_t;

  // ROM loader write port
  typedef struct packed {
    logic [`NH_ADDR_W-1:0] addr;
    logic [`NH_DATA_W-1:0] data;
    logic                  write;
    logic                  refresh;
  } loader_wr_t;

  // single command bus into the memory controller
  typedef struct packed {
    logic                  read_a; // cpu port
    logic                  read_b; // ppu port
    logic                  write;
    logic                  refresh;
    logic [`NH_ADDR_W-1:0] addr;
    logic [`NH_DATA_W-1:0] din;
  } mem_cmd_t;

endpackage

`default_nettype wire

// ==== logic/host_bus_pkg.sv ====
// host bus types
// UART register writes and the byte stream handed to the ROM loader

`default_nettype none

`include "nes_host_params.svh"

package host_bus_pkg;

  // register addresses seen on the framed UART stream
  typedef enum logic [7:0] {
    reg_conf = `NH_REG_CONF,
    reg_rom  = `NH_REG_ROM,
    reg_btn1 = `NH_REG_BTN1,
    reg_btn2 = `NH_REG_BTN2
  } uart_reg_e;

  // one framed UART write, valid for a single cycle
  typedef struct packed {
    uart_reg_e               addr;
    logic [`NH_DATA_W-1:0]   data;
    logic                    write; // strobe
  } uart_wr_t;

  // byte toward the ROM loader
  typedef struct packed {
    logic [`NH_DATA_W-1:0] data;
    logic                  strobe; // one cycle per byte
  } loader_byte_t;

endpackage

`default_nettype wire

// ==== logic/nes_host_params.svh ====
// NES host glue parameters
// register addresses, memory widths, slot timing and autofire rate

`ifndef NES_HOST_PARAMS_SVH
`define NES_HOST_PARAMS_SVH

// UART register map
`define NH_REG_CONF 8'h35 // loader configuration, bit 0 holds the loader in reset
`define NH_REG_ROM  8'h37 // ROM byte stream port
`define NH_REG_BTN1 8'h40 // loader buttons, port 1
`define NH_REG_BTN2 8'h41 // loader buttons, port 2

// memory bus widths
`define NH_ADDR_W 22 // 4MB space
`define NH_DATA_W 8

// slot sequencer
`define NH_PHASES    5 // clocks per console step
`define NH_NES_PHASE 4 // console runs on the last phase

// autofire half period in clocks
// short for simulation, a board build wants a few million
`define NH_AUTOFIRE_HALF 4

`endif
